//--- src/mem_share_params.svh
// Size macros for the shared-memory subsystem
// Include this file before any module or package that needs a width or a depth

`ifndef MEM_SHARE_PARAMS_SVH
`define MEM_SHARE_PARAMS_SVH

// Width of one memory word and of the write and read data buses
`define MS_DATA_W 32

// Word address width, enough to index every word of the bank
`define MS_ADDR_W 6

// Number of words held by the single SRAM bank
`define MS_DEPTH 64

// Width of the saturating per-port counter of requests dropped by abort
`define MS_CNT_W 8

`endif

//--- src/mem_share_pkg.sv
// Types shared by the shared-memory RTL and its testbench
// Modules pull these in with a wildcard import in the module header

`include "mem_share_params.svh"

package mem_share_pkg;

  // Opcode carried with every request from a port to the bank
  // A read returns the stored word with the response strobe
  // A write stores the word and the strobe only acknowledges it
  typedef enum logic [0:0] {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } op_e;

endpackage

//--- src/spill_register_flushable.sv
// Two-entry handshake register that breaks every combinational path from input to output
// A flush empties both entries in one cycle, and Bypass turns the block into plain wires

`timescale 1ns/1ps

`include "mem_share_params.svh"

module spill_register_flushable #(
  parameter bit Bypass = 1'b0
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  valid_i,
  input  logic                  flush_i,
  output logic                  ready_o,
  input  logic                  op_i,
  input  logic [`MS_ADDR_W-1:0] addr_i,
  input  logic [`MS_DATA_W-1:0] wdata_i,
  output logic                  valid_o,
  input  logic                  ready_i,
  output logic                  op_o,
  output logic [`MS_ADDR_W-1:0] addr_o,
  output logic [`MS_DATA_W-1:0] wdata_o
);

  if (Bypass) begin : gen_bypass
    // Transparent variant with handshake and payload passed straight through
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign op_o    = op_i;
    assign addr_o  = addr_i;
    assign wdata_o = wdata_i;
  end else begin : gen_spill
    // Stage A takes new input, stage B holds what A could not hand on
    logic                  a_full_q, b_full_q;
    logic                  a_op_q, b_op_q;
    logic [`MS_ADDR_W-1:0] a_addr_q, b_addr_q;
    logic [`MS_DATA_W-1:0] a_wdata_q, b_wdata_q;
    logic                  a_fill, a_drain;
    logic                  b_fill, b_drain;

    // Stage A loads on an input handshake, never during a flush
    assign a_fill  = valid_i && ready_o && !flush_i;
    // A empties when B is free to take it or the output accepts it, or on flush
    assign a_drain = (a_full_q && !b_full_q) || flush_i;

    // Data leaving A moves into B only if the output is stalled
    assign b_fill  = a_drain && !ready_i && !flush_i;
    assign b_drain = (b_full_q && ready_i) || flush_i;

    // Input readiness only looks at local state, so ready_i never reaches ready_o
    assign ready_o = !a_full_q || !b_full_q;
    assign valid_o = a_full_q || b_full_q;

    // The older word sits in B, so B goes out first
    assign op_o    = b_full_q ? b_op_q    : a_op_q;
    assign addr_o  = b_full_q ? b_addr_q  : a_addr_q;
    assign wdata_o = b_full_q ? b_wdata_q : a_wdata_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_fill || a_drain) begin
          a_full_q <= a_fill;
        end
        if (b_fill || b_drain) begin
          b_full_q <= b_fill;
        end
      end
    end

    // Payload stages only load on a fill and need no reset
    always_ff @(posedge clk_i) begin
      if (a_fill) begin
        a_op_q    <= op_i;
        a_addr_q  <= addr_i;
        a_wdata_q <= wdata_i;
      end
      if (b_fill) begin
        b_op_q    <= a_op_q;
        b_addr_q  <= a_addr_q;
        b_wdata_q <= a_wdata_q;
      end
    end
  end

endmodule

//--- src/port_frontend.sv
// Per-port request front end built around the flushable spill register
// An abort strobe flushes the held requests and adds their number to a saturating counter

`timescale 1ns/1ps

`include "mem_share_params.svh"

module port_frontend import mem_share_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  op_e                   op_i,
  input  logic [`MS_ADDR_W-1:0] addr_i,
  input  logic [`MS_DATA_W-1:0] wdata_i,
  input  logic                  abort_i,
  output logic                  arb_valid_o,
  input  logic                  arb_ready_i,
  output op_e                   arb_op_o,
  output logic [`MS_ADDR_W-1:0] arb_addr_o,
  output logic [`MS_DATA_W-1:0] arb_wdata_o,
  output logic [`MS_CNT_W-1:0]  dropped_o
);

  logic                 spill_ready, spill_valid, spill_op;
  logic                 accept, issue;
  logic [1:0]           occ_q, occ_d;
  logic [`MS_CNT_W-1:0] dropped_q;
  logic [`MS_CNT_W:0]   drop_sum;

  // Abort masks both handshakes so the flush never meets a transfer
  assign req_ready_o = spill_ready && !abort_i;
  assign arb_valid_o = spill_valid && !abort_i;
  assign arb_op_o    = op_e'(spill_op);

  spill_register_flushable #(
    .Bypass  (1'b0)
  ) i_spill (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (req_valid_i && !abort_i),
    .flush_i (abort_i),
    .ready_o (spill_ready),
    .op_i    (op_i),
    .addr_i  (addr_i),
    .wdata_i (wdata_i),
    .valid_o (spill_valid),
    .ready_i (arb_ready_i),
    .op_o    (spill_op),
    .addr_o  (arb_addr_o),
    .wdata_o (arb_wdata_o)
  );

  assign accept = req_valid_i && req_ready_o;
  assign issue  = arb_valid_o && arb_ready_i;

  // Occupancy follows both handshakes and drops to zero with the flush
  always_comb begin
    occ_d = occ_q;
    if (abort_i) begin
      occ_d = 2'd0;
    end else if (accept && !issue) begin
      occ_d = occ_q + 2'd1;
    end else if (!accept && issue) begin
      occ_d = occ_q - 2'd1;
    end
  end

  // One extra bit catches the carry for saturation
  assign drop_sum  = {1'b0, dropped_q} + {{(`MS_CNT_W-1){1'b0}}, occ_q};
  assign dropped_o = dropped_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occ_q     <= 2'd0;
      dropped_q <= '0;
    end else begin
      occ_q <= occ_d;
      if (abort_i) begin
        // Counter sticks at all ones once it would wrap
        dropped_q <= drop_sum[`MS_CNT_W] ? '1 : drop_sum[`MS_CNT_W-1:0];
      end
    end
  end

endmodule

//--- src/rr_arbiter.sv
// Two-way round-robin arbiter in front of the single memory bank
// Grants one port per cycle and drives the winner's request onto the memory bus

`timescale 1ns/1ps

`include "mem_share_params.svh"

module rr_arbiter import mem_share_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  p0_valid_i,
  input  op_e                   p0_op_i,
  input  logic [`MS_ADDR_W-1:0] p0_addr_i,
  input  logic [`MS_DATA_W-1:0] p0_wdata_i,
  output logic                  p0_ready_o,
  input  logic                  p1_valid_i,
  input  op_e                   p1_op_i,
  input  logic [`MS_ADDR_W-1:0] p1_addr_i,
  input  logic [`MS_DATA_W-1:0] p1_wdata_i,
  output logic                  p1_ready_o,
  output logic                  mem_en_o,
  output op_e                   mem_op_o,
  output logic [`MS_ADDR_W-1:0] mem_addr_o,
  output logic [`MS_DATA_W-1:0] mem_wdata_o,
  output logic                  mem_port_o
);

  // Port number of the most recent grant
  logic last_q;
  logic gnt0, gnt1;

  // Port 1 wins when alone or when port 0 held the last grant
  assign gnt1 = p1_valid_i && (!p0_valid_i || !last_q);
  assign gnt0 = p0_valid_i && !gnt1;

  // The bank is always ready, so a grant is the ready of that port
  assign p0_ready_o = gnt0;
  assign p1_ready_o = gnt1;

  assign mem_en_o   = gnt0 || gnt1;
  assign mem_port_o = gnt1;

  // Fields follow the winner, and they are don't-care when nothing is granted
  always_comb begin
    if (gnt1) begin
      mem_op_o    = p1_op_i;
      mem_addr_o  = p1_addr_i;
      mem_wdata_o = p1_wdata_i;
    end else begin
      mem_op_o    = p0_op_i;
      mem_addr_o  = p0_addr_i;
      mem_wdata_o = p0_wdata_i;
    end
  end

  // Out of reset the pointer says port 1, so port 0 takes the first tie
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q <= 1'b1;
    end else if (mem_en_o) begin
      last_q <= gnt1;
    end
  end

endmodule

//--- src/sram_bank.sv
// Single-port word memory shared by both request ports
// Performs one access per cycle and strobes the owning port's response a cycle later

`timescale 1ns/1ps

`include "mem_share_params.svh"

module sram_bank import mem_share_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  mem_en_i,
  input  op_e                   mem_op_i,
  input  logic [`MS_ADDR_W-1:0] mem_addr_i,
  input  logic [`MS_DATA_W-1:0] mem_wdata_i,
  input  logic                  mem_port_i,
  output logic                  p0_rsp_valid_o,
  output logic                  p1_rsp_valid_o,
  output logic [`MS_DATA_W-1:0] rdata_o
);

  logic [`MS_DATA_W-1:0] mem_q [`MS_DEPTH];
  logic [`MS_DATA_W-1:0] rdata_q;
  logic                  rsp_q;
  logic                  port_q;
  logic                  wr_en, rd_en;

  assign wr_en = mem_en_i && (mem_op_i == OP_WRITE);
  assign rd_en = mem_en_i && (mem_op_i == OP_READ);

  // Word array clears to zero so unwritten addresses read back as zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `MS_DEPTH; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_en) begin
      mem_q[mem_addr_i] <= mem_wdata_i;
    end
  end

  // Read data only changes on a read, a write ack leaves it alone
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= mem_q[mem_addr_i];
    end
  end

  // Response strobe and owning port follow every access by one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_q  <= 1'b0;
      port_q <= 1'b0;
    end else begin
      rsp_q <= mem_en_i;
      if (mem_en_i) begin
        port_q <= mem_port_i;
      end
    end
  end

  // Each strobe is a single cycle since rsp_q is refreshed every cycle
  assign p0_rsp_valid_o = rsp_q && !port_q;
  assign p1_rsp_valid_o = rsp_q && port_q;
  assign rdata_o        = rdata_q;

endmodule

//--- src/mem_share_top.sv
// Top level of the shared-memory subsystem
// Two request ports pass through their front ends and the arbiter into one SRAM bank

`timescale 1ns/1ps

`include "mem_share_params.svh"

module mem_share_top import mem_share_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  p0_req_valid_i,
  output logic                  p0_req_ready_o,
  input  op_e                   p0_op_i,
  input  logic [`MS_ADDR_W-1:0] p0_addr_i,
  input  logic [`MS_DATA_W-1:0] p0_wdata_i,
  input  logic                  p0_abort_i,
  output logic                  p0_rsp_valid_o,
  output logic [`MS_DATA_W-1:0] p0_rdata_o,
  output logic [`MS_CNT_W-1:0]  p0_dropped_o,
  input  logic                  p1_req_valid_i,
  output logic                  p1_req_ready_o,
  input  op_e                   p1_op_i,
  input  logic [`MS_ADDR_W-1:0] p1_addr_i,
  input  logic [`MS_DATA_W-1:0] p1_wdata_i,
  input  logic                  p1_abort_i,
  output logic                  p1_rsp_valid_o,
  output logic [`MS_DATA_W-1:0] p1_rdata_o,
  output logic [`MS_CNT_W-1:0]  p1_dropped_o
);

  // Front end to arbiter, one set per port
  logic                  p0_arb_valid, p0_arb_ready;
  logic                  p1_arb_valid, p1_arb_ready;
  op_e                   p0_arb_op, p1_arb_op;
  logic [`MS_ADDR_W-1:0] p0_arb_addr, p1_arb_addr;
  logic [`MS_DATA_W-1:0] p0_arb_wdata, p1_arb_wdata;

  // Arbiter to memory bank
  logic                  mem_en, mem_port;
  op_e                   mem_op;
  logic [`MS_ADDR_W-1:0] mem_addr;
  logic [`MS_DATA_W-1:0] mem_wdata, rdata;

  port_frontend i_p0_frontend (
    .clk_i       (clk_i),          .rst_ni      (rst_ni),
    .req_valid_i (p0_req_valid_i), .req_ready_o (p0_req_ready_o),
    .op_i        (p0_op_i),        .addr_i      (p0_addr_i),
    .wdata_i     (p0_wdata_i),     .abort_i     (p0_abort_i),
    .arb_valid_o (p0_arb_valid),   .arb_ready_i (p0_arb_ready),
    .arb_op_o    (p0_arb_op),      .arb_addr_o  (p0_arb_addr),
    .arb_wdata_o (p0_arb_wdata),   .dropped_o   (p0_dropped_o)
  );

  port_frontend i_p1_frontend (
    .clk_i       (clk_i),          .rst_ni      (rst_ni),
    .req_valid_i (p1_req_valid_i), .req_ready_o (p1_req_ready_o),
    .op_i        (p1_op_i),        .addr_i      (p1_addr_i),
    .wdata_i     (p1_wdata_i),     .abort_i     (p1_abort_i),
    .arb_valid_o (p1_arb_valid),   .arb_ready_i (p1_arb_ready),
    .arb_op_o    (p1_arb_op),      .arb_addr_o  (p1_arb_addr),
    .arb_wdata_o (p1_arb_wdata),   .dropped_o   (p1_dropped_o)
  );

  rr_arbiter i_arbiter (
    .clk_i       (clk_i),        .rst_ni      (rst_ni),
    .p0_valid_i  (p0_arb_valid), .p0_op_i     (p0_arb_op),
    .p0_addr_i   (p0_arb_addr),  .p0_wdata_i  (p0_arb_wdata),
    .p0_ready_o  (p0_arb_ready),
    .p1_valid_i  (p1_arb_valid), .p1_op_i     (p1_arb_op),
    .p1_addr_i   (p1_arb_addr),  .p1_wdata_i  (p1_arb_wdata),
    .p1_ready_o  (p1_arb_ready),
    .mem_en_o    (mem_en),       .mem_op_o    (mem_op),
    .mem_addr_o  (mem_addr),     .mem_wdata_o (mem_wdata),
    .mem_port_o  (mem_port)
  );

  sram_bank i_bank (
    .clk_i          (clk_i),          .rst_ni         (rst_ni),
    .mem_en_i       (mem_en),         .mem_op_i       (mem_op),
    .mem_addr_i     (mem_addr),       .mem_wdata_i    (mem_wdata),
    .mem_port_i     (mem_port),
    .p0_rsp_valid_o (p0_rsp_valid_o), .p1_rsp_valid_o (p1_rsp_valid_o),
    .rdata_o        (rdata)
  );

  // Read data is shared, and the strobe tells which port owns it
  assign p0_rdata_o = rdata;
  assign p1_rdata_o = rdata;

endmodule

//--- tests/tb_mem_share.sv
// Self-checking testbench for the shared-memory subsystem
// Runs a stimulus table through both ports and checks every response against a memory model

`timescale 1ns/1ps

`include "mem_share_params.svh"

module tb_mem_share import mem_share_pkg::*; ();

  localparam int AcceptLimit = 200;
  localparam int DrainLimit  = 500;
  localparam int TabSize     = 64;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  req_valid [2];
  logic                  req_ready [2];
  op_e                   req_op    [2];
  logic [`MS_ADDR_W-1:0] req_addr  [2];
  logic [`MS_DATA_W-1:0] req_wdata [2];
  logic                  abort     [2];
  logic                  rsp_valid [2];
  logic [`MS_DATA_W-1:0] rdata     [2];
  logic [`MS_CNT_W-1:0]  dropped   [2];

  // Stimulus table, one row per request or abort
  int                    tab_port  [TabSize];
  op_e                   tab_op    [TabSize];
  logic [`MS_ADDR_W-1:0] tab_addr  [TabSize];
  logic [`MS_DATA_W-1:0] tab_wdata [TabSize];
  logic                  tab_abort [TabSize];
  int                    n_rows;

  // Memory model updated in acceptance order, plus expected responses per port
  logic [`MS_DATA_W-1:0] model [`MS_DEPTH];
  logic                  exp_rd_q0 [$];
  logic                  exp_rd_q1 [$];
  logic [`MS_DATA_W-1:0] exp_data_q0 [$];
  logic [`MS_DATA_W-1:0] exp_data_q1 [$];

  int accepted [2];
  int responded [2];
  int ready_low_cnt [2];
  int gap_max [2];
  bit check_alt;
  int last_rsp;
  int drop_exp;

  always #4 clk = ~clk;

  mem_share_top i_mem_share_top (
    .clk_i          (clk),          .rst_ni         (rst_n),
    .p0_req_valid_i (req_valid[0]), .p0_req_ready_o (req_ready[0]),
    .p0_op_i        (req_op[0]),    .p0_addr_i      (req_addr[0]),
    .p0_wdata_i     (req_wdata[0]), .p0_abort_i     (abort[0]),
    .p0_rsp_valid_o (rsp_valid[0]), .p0_rdata_o     (rdata[0]),
    .p0_dropped_o   (dropped[0]),
    .p1_req_valid_i (req_valid[1]), .p1_req_ready_o (req_ready[1]),
    .p1_op_i        (req_op[1]),    .p1_addr_i      (req_addr[1]),
    .p1_wdata_i     (req_wdata[1]), .p1_abort_i     (abort[1]),
    .p1_rsp_valid_o (rsp_valid[1]), .p1_rdata_o     (rdata[1]),
    .p1_dropped_o   (dropped[1])
  );

  task automatic stop_with_failure();
    $display("Simulation failed");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic check_rdata(input logic [`MS_DATA_W-1:0] got, input logic [`MS_DATA_W-1:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("Error at %0t ns: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_dropped(input logic [`MS_CNT_W-1:0] got, input logic [`MS_CNT_W-1:0] exp,
                               input string what);
    if (got !== exp) begin
      $display("Error at %0t ns: %s dropped count %0d, expected %0d", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic clear_table();
    n_rows = 0;
  endtask

  task automatic add_row(input int p, input op_e op, input int addr,
                         input logic [`MS_DATA_W-1:0] wdata, input logic abrt);
    if (n_rows >= TabSize) begin
      $display("Stimulus table is full, row for port %0d does not fit", p);
      stop_with_failure();
    end else begin
      tab_port[n_rows]  = p;
      tab_op[n_rows]    = op;
      tab_addr[n_rows]  = addr[`MS_ADDR_W-1:0];
      tab_wdata[n_rows] = wdata;
      tab_abort[n_rows] = abrt;
      n_rows++;
    end
  endtask

  // A read expects whatever the model holds when the request is accepted
  task automatic record_accept(input int p, input op_e op, input logic [`MS_ADDR_W-1:0] addr,
                               input logic [`MS_DATA_W-1:0] wdata);
    logic [`MS_DATA_W-1:0] exp_data;
    exp_data = model[addr];
    if (op == OP_WRITE) begin
      model[addr] = wdata;
    end
    if (p == 0) begin
      exp_rd_q0.push_back(op == OP_READ);
      exp_data_q0.push_back(exp_data);
    end else begin
      exp_rd_q1.push_back(op == OP_READ);
      exp_data_q1.push_back(exp_data);
    end
    accepted[p]++;
  endtask

  // Walks the table and applies this port's rows, holding valid until ready is seen
  task automatic drive_port(input int p);
    int gap;
    int wait_cnt;
    bit taken;
    for (int i = 0; i < n_rows; i++) begin
      if (tab_port[i] == p) begin
        gap = $urandom % (gap_max[p] + 1);
        if (gap > 0) begin
          req_valid[p] = 1'b0;
          repeat (gap) @(negedge clk);
        end
        if (tab_abort[i]) begin
          req_valid[p] = 1'b0;
          abort[p]     = 1'b1;
          @(negedge clk);
          abort[p]     = 1'b0;
        end else begin
          req_valid[p] = 1'b1;
          req_op[p]    = tab_op[i];
          req_addr[p]  = tab_addr[i];
          req_wdata[p] = tab_wdata[i];
          wait_cnt     = 0;
          taken        = 1'b0;
          while (!taken && wait_cnt < AcceptLimit) begin
            // Ready only depends on held state, so it is settled shortly after the drive
            #1;
            if (req_ready[p]) begin
              taken = 1'b1;
              record_accept(p, tab_op[i], tab_addr[i], tab_wdata[i]);
            end else begin
              ready_low_cnt[p]++;
              wait_cnt++;
            end
            @(negedge clk);
          end
          if (!taken) begin
            $display("Timeout: port %0d row %0d was never accepted", p, i);
            stop_with_failure();
          end
        end
      end
    end
    req_valid[p] = 1'b0;
  endtask

  task automatic run_table();
    @(negedge clk);
    fork
      drive_port(0);
      drive_port(1);
    join
  endtask

  task automatic wait_drain(input int p);
    int cycles;
    cycles = 0;
    while (responded[p] != accepted[p] && cycles < DrainLimit) begin
      @(posedge clk);
      cycles++;
    end
    if (responded[p] != accepted[p]) begin
      $display("Timeout: port %0d still misses %0d responses", p, accepted[p] - responded[p]);
      stop_with_failure();
    end
  endtask

  task automatic take_response(input int p);
    logic                  is_rd;
    logic [`MS_DATA_W-1:0] exp_data;
    if ((p == 0 && exp_rd_q0.size() == 0) || (p == 1 && exp_rd_q1.size() == 0)) begin
      $display("Error at %0t ns: port %0d got a response with nothing outstanding", $time, p);
      stop_with_failure();
    end else begin
      if (p == 0) begin
        is_rd    = exp_rd_q0.pop_front();
        exp_data = exp_data_q0.pop_front();
      end else begin
        is_rd    = exp_rd_q1.pop_front();
        exp_data = exp_data_q1.pop_front();
      end
      // Write acks carry no data worth checking
      if (is_rd) begin
        check_rdata(rdata[p], exp_data, $sformatf("port %0d", p));
      end
      responded[p]++;
    end
  endtask

  // Strobes are stable in the middle of the cycle
  always @(negedge clk) begin
    if (rst_n) begin
      if (rsp_valid[0] && rsp_valid[1]) begin
        $display("Error at %0t ns: both ports got a response in the same cycle", $time);
        stop_with_failure();
      end else begin
        for (int p = 0; p < 2; p++) begin
          if (rsp_valid[p]) begin
            if (check_alt && last_rsp == p) begin
              $display("Error at %0t ns: port %0d won twice in a row under contention",
                       $time, p);
              stop_with_failure();
            end else begin
              last_rsp = p;
              take_response(p);
            end
          end
        end
      end
    end
  end

  initial begin
    void'($urandom(1366));
    rst_n     = 1'b0;
    n_rows    = 0;
    check_alt = 1'b0;
    last_rsp  = -1;
    drop_exp  = 0;
    for (int p = 0; p < 2; p++) begin
      req_valid[p]     = 1'b0;
      req_op[p]        = OP_READ;
      req_addr[p]      = '0;
      req_wdata[p]     = '0;
      abort[p]         = 1'b0;
      accepted[p]      = 0;
      responded[p]     = 0;
      ready_low_cnt[p] = 0;
      gap_max[p]       = 0;
    end
    for (int i = 0; i < `MS_DEPTH; i++) begin
      model[i] = '0;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // Idle state right after reset
    for (int p = 0; p < 2; p++) begin
      check_flag(rsp_valid[p], 1'b0, $sformatf("port %0d response strobe", p));
      check_flag(req_ready[p], 1'b1, $sformatf("port %0d request ready", p));
      check_dropped(dropped[p], '0, $sformatf("port %0d", p));
    end

    // Single port write then read back, plus an address nobody wrote
    clear_table();
    add_row(0, OP_WRITE, 5, $urandom, 1'b0);
    add_row(0, OP_READ, 5, '0, 1'b0);
    add_row(0, OP_READ, 9, '0, 1'b0);
    add_row(0, OP_WRITE, 9, $urandom, 1'b0);
    add_row(0, OP_READ, 9, '0, 1'b0);
    run_table();
    wait_drain(0);

    // Both ports on disjoint ranges, port 0 never idles while port 1 has random gaps
    clear_table();
    gap_max[1] = 3;
    for (int i = 0; i < 8; i++) begin
      add_row(0, OP_WRITE, 16 + i, $urandom, 1'b0);
      add_row(1, OP_WRITE, 32 + i, $urandom, 1'b0);
    end
    for (int i = 0; i < 8; i++) begin
      add_row(0, OP_READ, 16 + i, '0, 1'b0);
      add_row(1, OP_READ, 39 - i, '0, 1'b0);
    end
    run_table();
    wait_drain(0);
    wait_drain(1);

    // Both ports backlogged with equal loads, so grants must alternate
    clear_table();
    gap_max[1] = 0;
    for (int i = 0; i < 12; i++) begin
      add_row(0, (i % 2 == 0) ? OP_WRITE : OP_READ, 24 + i / 2, $urandom, 1'b0);
      add_row(1, (i % 2 == 0) ? OP_WRITE : OP_READ, 40 + i / 2, $urandom, 1'b0);
    end
    last_rsp  = -1;
    check_alt = 1'b1;
    run_table();
    wait_drain(0);
    wait_drain(1);
    check_alt = 1'b0;
    if (ready_low_cnt[0] == 0) begin
      $display("Port 0 never saw back-pressure while both ports were backlogged");
      stop_with_failure();
    end

    // Port 1 queues reads under contention, then aborts what it holds
    clear_table();
    for (int i = 0; i < 10; i++) begin
      add_row(0, OP_READ, 16 + i % 8, '0, 1'b0);
    end
    for (int i = 0; i < 6; i++) begin
      add_row(1, OP_READ, 32 + i, '0, 1'b0);
    end
    add_row(1, OP_READ, 0, '0, 1'b1);
    run_table();
    wait_drain(0);
    // A granted request answers one cycle later, so nothing from port 1 can still arrive
    repeat (2) @(posedge clk);
    drop_exp = accepted[1] - responded[1];
    if (drop_exp == 0) begin
      $display("Abort found port 1 empty, so no request was dropped");
      stop_with_failure();
    end
    check_dropped(dropped[1], drop_exp[`MS_CNT_W-1:0], "port 1 after abort");
    check_dropped(dropped[0], '0, "port 0 after abort");
    exp_rd_q1.delete();
    exp_data_q1.delete();
    accepted[1] = responded[1];

    // Port 1 keeps working after the flush and its counter holds
    clear_table();
    add_row(1, OP_WRITE, 50, $urandom, 1'b0);
    add_row(1, OP_READ, 50, '0, 1'b0);
    run_table();
    wait_drain(1);
    check_dropped(dropped[1], drop_exp[`MS_CNT_W-1:0], "port 1 after recovery");
    check_dropped(dropped[0], '0, "port 0 at the end");

    $display("Simulation passed");
    $finish;
  end

endmodule

//--- list.f
+incdir+src
src/mem_share_pkg.sv
src/spill_register_flushable.sv
src/port_frontend.sv
src/rr_arbiter.sv
src/sram_bank.sv
src/mem_share_top.sv
tests/tb_mem_share.sv
